// ==== project.f ====
hw/tmu_pkg.sv
hw/tmu_ctlif.sv
hw/tmu_decay.sv
hw/tmu_fdest.sv
hw/tmu_alpha.sv
hw/tmu_burst.sv
hw/tmu_top.sv
tb/tb_tmu_check.sv
tb/tb_tmu.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tmu \
	-f project.f -o tb_tmu \
	&& ./obj_dir/tb_tmu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// ==== tb/tb_tmu.sv ====
/*
 * Testbench top for the TMU pixel back end.
 * Drives clock, reset, the control registers and the pixel stream for
 * six short runs. The checker instance compares every framebuffer write
 * and prints failures; this module prints the closing summary.
 */
module tb_tmu;
	timeunit 1ns;
	timeprecision 100ps;
	import tmu_pkg::*;

	localparam int FML_DEPTH = 26;
	localparam int TIMEOUT_CYCLES = 4000;  // About eight times the six runs

	logic sys_clk;
	logic sys_rst;
	logic [13:0] csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i;
	logic [31:0] csr_do_o;
	logic pix_valid_i;
	logic pix_ready_o;
	logic [FML_DEPTH-2:0] pix_adr_i;
	rgb565_t pix_color_i;
	logic dr_valid_o;
	logic dr_ready_i;
	logic [FML_DEPTH-2:0] dr_adr_o;
	logic dr_rvalid_i;
	rgb565_t dr_rdata_i;
	logic fw_valid_o;
	logic fw_ready_i;
	logic [FML_DEPTH-4:0] fw_adr_o;
	logic [7:0] fw_sel_o;
	logic [63:0] fw_data_o;
	logic irq_o;

	int test_num;
	int cycles;
	int errors;
	int words;
	level_t brightness;
	level_t alpha;
	logic chroma_en;
	logic [15:0] chroma_key;
	logic [31:0] color_seed;
	logic [31:0] ready_seed;
	logic stall_mode;
	logic pix_xfer;
	logic idle_check;

	always #5 sys_clk = ~sys_clk;

	tmu_top #(
		.fml_depth(FML_DEPTH),
		.csr_addr(4'h0)
	) tmu_top_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
		.pix_valid_i(pix_valid_i), .pix_ready_o(pix_ready_o),
		.pix_adr_i(pix_adr_i), .pix_color_i(pix_color_i),
		.dr_valid_o(dr_valid_o), .dr_ready_i(dr_ready_i), .dr_adr_o(dr_adr_o),
		.dr_rvalid_i(dr_rvalid_i), .dr_rdata_i(dr_rdata_i),
		.fw_valid_o(fw_valid_o), .fw_ready_i(fw_ready_i), .fw_adr_o(fw_adr_o),
		.fw_sel_o(fw_sel_o), .fw_data_o(fw_data_o),
		.irq_o(irq_o)
	);

	tb_tmu_check #(
		.fml_depth(FML_DEPTH)
	) check_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .test_i(test_num),
		.brightness_i(brightness), .alpha_i(alpha),
		.chroma_en_i(chroma_en), .chroma_key_i(chroma_key),
		.pix_valid_i(pix_valid_i), .pix_ready_i(pix_ready_o),
		.pix_adr_i(pix_adr_i), .pix_color_i(pix_color_i.raw),
		.dr_valid_i(dr_valid_o), .dr_ready_o(dr_ready_i), .dr_adr_i(dr_adr_o),
		.dr_rvalid_o(dr_rvalid_i), .dr_rdata_o(dr_rdata_i),
		.fw_valid_i(fw_valid_o), .fw_ready_i(fw_ready_i), .fw_adr_i(fw_adr_o),
		.fw_sel_i(fw_sel_o), .fw_data_i(fw_data_o),
		.irq_i(irq_o), .busy_bit_i(csr_do_o[0]), .idle_check_i(idle_check),
		.errors_o(errors), .words_o(words)
	);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Marks the edges where a pixel was taken
	always @(posedge sys_clk)
		pix_xfer <= pix_valid_i & pix_ready_o;

	always @(posedge sys_clk) begin
		#1;
		ready_seed = lcg(ready_seed);
		fw_ready_i = stall_mode ? ready_seed[27] : 1'b1;
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	task automatic write_reg(input int idx, input logic [31:0] data);
		@(posedge sys_clk);
		#1;
		csr_a_i = 14'(idx);
		csr_we_i = 1'b1;
		csr_di_i = data;
		@(posedge sys_clk);
		#1;
		csr_we_i = 1'b0;
	endtask

	task automatic set_mode(input level_t b, input level_t a, input logic en,
		input logic [15:0] key);
		brightness = b;
		alpha = a;
		chroma_en = en;
		chroma_key = key;
		write_reg(REG_BRIGHTNESS, {26'd0, b});
		write_reg(REG_ALPHA, {26'd0, a});
		write_reg(REG_CHROMA, {15'd0, en, key});
	endtask

	// One run of n pixels from base where pixels flagged in key_mask carry the key
	task automatic run_pixels(input int test, input logic [FML_DEPTH-2:0] base,
		input int n, input logic [15:0] key_mask);
		logic [15:0] c;
		test_num = test;
		write_reg(REG_COUNT, 32'(n));
		write_reg(REG_CTRL, 32'd1);
		for (int i = 0; i < n; i++) begin
			color_seed = lcg(color_seed);
			c = color_seed[30:15];
			if (key_mask[i])
				c = chroma_key;
			else if (chroma_en && c == chroma_key)
				c = c ^ 16'h0001;
			pix_valid_i = 1'b1;
			pix_adr_i = base + (FML_DEPTH-1)'(i);
			pix_color_i.raw = c;
			do begin
				@(posedge sys_clk);
				#1;
			end while (!pix_xfer);
		end
		pix_valid_i = 1'b0;
		do begin
			@(posedge sys_clk);
			#1;
		end while (!irq_o);
		csr_a_i = 14'(REG_CTRL);  // Read back busy after the interrupt
		@(posedge sys_clk);
		#1;
		idle_check = 1'b1;
		@(posedge sys_clk);
		#1;
		idle_check = 1'b0;
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		pix_valid_i = 1'b0;
		pix_adr_i = '0;
		pix_color_i = '0;
		fw_ready_i = 1'b1;
		test_num = 0;
		cycles = 0;
		brightness = LEVEL_MAX;
		alpha = LEVEL_MAX;
		chroma_en = 1'b0;
		chroma_key = '0;
		color_seed = 32'd35;
		ready_seed = 32'd35;
		stall_mode = 1'b0;
		idle_check = 1'b0;
		repeat (10) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		// ####################
		set_mode(LEVEL_MAX, LEVEL_MAX, 1'b0, 16'h0000);
		run_pixels(1, 25'h100, 4, 16'h0000);
		set_mode(6'd20, LEVEL_MAX, 1'b0, 16'h0000);
		run_pixels(2, 25'h200, 8, 16'h0000);
		set_mode(LEVEL_MAX, LEVEL_MAX, 1'b1, 16'hf81f);
		run_pixels(3, 25'h300, 8, 16'h0024);
		set_mode(LEVEL_MAX, 6'd40, 1'b0, 16'h0000);
		run_pixels(4, 25'h400, 8, 16'h0000);
		set_mode(6'd50, LEVEL_MAX, 1'b0, 16'h0000);
		run_pixels(5, 25'h501, 6, 16'h0000);  // Starts and ends inside a word

		@(negedge sys_clk);
		stall_mode = 1'b1;
		set_mode(6'd45, 6'd40, 1'b0, 16'h0000);
		run_pixels(6, 25'h600, 12, 16'h0000);
		@(negedge sys_clk);
		stall_mode = 1'b0;

		repeat (5) @(posedge sys_clk);
		$display("Summary: %0d words written, %0d errors", words, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== tb/tb_tmu_check.sv ====
/*
 * Checker for the TMU pixel back end testbench.
 * Models the destination memory side, predicts every framebuffer write
 * from the pixels taken at the input and the programmed registers, and
 * holds the concurrent assertions that compare them with the DUT.
 */
module tb_tmu_check #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,
	input int test_i,

	input tmu_pkg::level_t brightness_i,
	input tmu_pkg::level_t alpha_i,
	input logic chroma_en_i,
	input logic [15:0] chroma_key_i,

	input logic pix_valid_i,
	input logic pix_ready_i,
	input logic [fml_depth-2:0] pix_adr_i,
	input logic [15:0] pix_color_i,

	input logic dr_valid_i,
	output logic dr_ready_o,
	input logic [fml_depth-2:0] dr_adr_i,
	output logic dr_rvalid_o,
	output tmu_pkg::rgb565_t dr_rdata_o,

	input logic fw_valid_i,
	input logic fw_ready_i,
	input logic [fml_depth-4:0] fw_adr_i,
	input logic [7:0] fw_sel_i,
	input logic [63:0] fw_data_i,

	input logic irq_i,
	input logic busy_bit_i,
	input logic idle_check_i,

	output int errors_o,
	output int words_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import tmu_pkg::*;

	localparam int QD = 64;

	int errors;
	int words;
	int reads_seen;
	int reads_exp;

	function automatic string test_name(input int t);
		case (t)
			1: return "full word";
			2: return "brightness";
			3: return "chroma key";
			4: return "blend";
			5: return "partial word";
			6: return "write stall";
			default: return "reset";
		endcase
	endfunction

	// Destination memory content, a hash of the whole pixel address
	function automatic logic [15:0] dest_pixel(input logic [fml_depth-2:0] adr);
		logic [31:0] h;
		h = 32'(adr) * 32'h9e3779b1;
		return h[31:16] ^ h[15:0];
	endfunction

	// Decay then blend, straight from the channel formulas
	function automatic logic [15:0] predict(input logic [15:0] c,
		input logic [fml_depth-2:0] adr);
		rgb565_t s;
		rgb565_t d;
		rgb565_t o;
		int bw;
		int aw;
		s.raw = c;
		bw = int'(brightness_i) + 1;
		s.ch.r = 5'((int'(s.ch.r) * bw) / 64);
		s.ch.g = 6'((int'(s.ch.g) * bw) / 64);
		s.ch.b = 5'((int'(s.ch.b) * bw) / 64);
		o = s;
		if (alpha_i != LEVEL_MAX) begin
			d.raw = dest_pixel(adr);
			aw = int'(alpha_i) + 1;
			o.ch.r = 5'((int'(s.ch.r) * aw + int'(d.ch.r) * (64 - aw)) / 64);
			o.ch.g = 6'((int'(s.ch.g) * aw + int'(d.ch.g) * (64 - aw)) / 64);
			o.ch.b = 5'((int'(s.ch.b) * aw + int'(d.ch.b) * (64 - aw)) / 64);
		end
		return o.raw;
	endfunction

	task automatic report_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("[FAIL] %s: %s expected %h, actual %h", test_name(test_i), what, exp, act);
	endtask

	task automatic report_event(input string what);
		errors++;
		$display("[FAIL] %s: %s", test_name(test_i), what);
	endtask

	// ####################
	// Destination memory, answers two cycles after each request
	logic req_d1;
	logic [fml_depth-2:0] adr_d1;
	logic rsp_valid;
	logic [15:0] rsp_data;

	assign dr_ready_o = 1'b1;

	initial begin
		dr_rvalid_o = 1'b0;
		dr_rdata_o = '0;
	end

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			req_d1 <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			req_d1 <= dr_valid_i & dr_ready_o;
			adr_d1 <= dr_adr_i;
			rsp_valid <= req_d1;
			rsp_data <= dest_pixel(adr_d1);
		end
	end

	always @(posedge sys_clk) begin
		#1;
		dr_rvalid_o = rsp_valid;
		dr_rdata_o.raw = rsp_data;
	end

	// ####################
	// Expected words, closed ones queued and one still open
	logic [fml_depth-4:0] q_adr [QD];
	logic [7:0] q_sel [QD];
	logic [63:0] q_data [QD];
	int wr_ptr;
	int rd_ptr;
	logic [fml_depth-4:0] open_adr;
	logic [7:0] open_sel;
	logic [63:0] open_data;

	always @(posedge sys_clk) begin
		logic [fml_depth-4:0] word;
		int lane;
		if (sys_rst) begin
			wr_ptr = 0;
			rd_ptr = 0;
			open_adr = '0;
			open_sel = '0;
			open_data = '0;
			words = 0;
			reads_seen = 0;
			reads_exp = 0;
		end else begin
			if (fw_valid_i & fw_ready_i) begin
				words++;
				if (rd_ptr != wr_ptr)
					rd_ptr++;
				else
					open_sel = '0;  // The flushed partial word
			end
			if (dr_valid_i & dr_ready_o)
				reads_seen++;
			if (pix_valid_i & pix_ready_i & ~(chroma_en_i & (pix_color_i == chroma_key_i))) begin
				word = pix_adr_i[fml_depth-2:2];
				lane = int'(pix_adr_i[1:0]);
				if (open_sel != 0 && word != open_adr) begin
					q_adr[wr_ptr % QD] = open_adr;
					q_sel[wr_ptr % QD] = open_sel;
					q_data[wr_ptr % QD] = open_data;
					wr_ptr++;
					open_sel = '0;
				end
				open_adr = word;
				open_sel = open_sel | (8'h03 << (2 * lane));
				open_data[16*lane +: 16] = predict(pix_color_i, pix_adr_i);
				if (alpha_i != LEVEL_MAX)
					reads_exp++;
			end
		end
	end

	logic have_q;
	logic [fml_depth-4:0] exp_adr;
	logic [7:0] exp_sel;
	logic [63:0] exp_data;
	logic [63:0] lane_mask;

	assign have_q = (rd_ptr != wr_ptr);
	assign exp_adr = have_q ? q_adr[rd_ptr % QD] : open_adr;
	assign exp_sel = have_q ? q_sel[rd_ptr % QD] : open_sel;
	assign exp_data = have_q ? q_data[rd_ptr % QD] : open_data;
	assign lane_mask = {{16{fw_sel_i[6]}}, {16{fw_sel_i[4]}}, {16{fw_sel_i[2]}},
		{16{fw_sel_i[0]}}};

	// ####################
	// Assertions
	a_word_adr: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fw_valid_i && fw_ready_i |-> fw_adr_i == exp_adr)
		else report_value("word address", 64'($sampled(exp_adr)), 64'($sampled(fw_adr_i)));

	a_word_sel: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fw_valid_i && fw_ready_i |-> fw_sel_i == exp_sel)
		else report_value("byte select", 64'($sampled(exp_sel)), 64'($sampled(fw_sel_i)));

	a_word_data: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fw_valid_i && fw_ready_i |-> (fw_data_i & lane_mask) == (exp_data & lane_mask))
		else report_value("write data", $sampled(exp_data & lane_mask),
			$sampled(fw_data_i & lane_mask));

	a_fw_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fw_valid_i && !fw_ready_i |=> fw_valid_i && $stable(fw_adr_i)
			&& $stable(fw_sel_i) && $stable(fw_data_i))
		else report_event("write word changed before the framebuffer took it");

	a_reads: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_i |-> reads_seen == reads_exp)
		else report_value("destination reads", 64'($sampled(reads_exp)),
			64'($sampled(reads_seen)));

	// Every predicted pixel must have left by the interrupt
	a_drained: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_i |-> !have_q && open_sel == 0)
		else report_event("pixels still expected when the run ended");

	a_irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_i |=> !irq_i)
		else report_event("interrupt held for more than one cycle");

	a_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		idle_check_i |-> !busy_bit_i)
		else report_value("busy bit", 64'd0, 64'($sampled(busy_bit_i)));

	assign errors_o = errors;
	assign words_o = words;

	initial errors = 0;

endmodule

// ==== hw/tmu_top.sv ====
/*
 * Top level of the TMU pixel back end.
 * Chains decay, destination fetch, alpha blend and burst assembly with
 * valid/ready links, gates the pixel input to the programmed count and
 * runs the flush sequence that ends each run with an interrupt.
 */
module tmu_top #(
	parameter int fml_depth = 26,
	parameter logic [3:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic [13:0] csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	input logic pix_valid_i,
	output logic pix_ready_o,
	input logic [fml_depth-2:0] pix_adr_i,
	input tmu_pkg::rgb565_t pix_color_i,

	output logic dr_valid_o,
	input logic dr_ready_i,
	output logic [fml_depth-2:0] dr_adr_o,
	input logic dr_rvalid_i,
	input tmu_pkg::rgb565_t dr_rdata_i,

	output logic fw_valid_o,
	input logic fw_ready_i,
	output logic [fml_depth-4:0] fw_adr_o,
	output logic [7:0] fw_sel_o,
	output logic [63:0] fw_data_o,

	output logic irq_o
);
	import tmu_pkg::*;

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] PROCESS = 2'd1;
	localparam logic [1:0] FLUSH = 2'd2;
	localparam logic [1:0] WAIT_FLUSH = 2'd3;

	logic start;
	logic busy;
	logic done;
	logic flush;
	level_t brightness;
	level_t alpha;
	logic chroma_en;
	rgb565_t chroma_key;
	logic [15:0] count;

	tmu_ctlif #(
		.csr_addr(csr_addr)
	) ctlif_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.done_i(done),
		.irq_o(irq_o),
		.start_o(start),
		.busy_o(busy),
		.brightness_o(brightness),
		.chroma_en_o(chroma_en),
		.chroma_key_o(chroma_key),
		.alpha_o(alpha),
		.count_o(count)
	);

	// ####################
	// Pixel stages
	logic run_open;
	logic decay_in_ready;
	logic decay_valid;
	logic decay_ready;
	logic [fml_depth-2:0] decay_adr;
	rgb565_t decay_color;

	logic fdest_valid;
	logic fdest_ready;
	logic [fml_depth-2:0] fdest_adr;
	rgb565_t fdest_color;
	rgb565_t fdest_dcolor;

	logic alpha_valid;
	logic alpha_ready;
	logic [fml_depth-2:0] alpha_adr;
	rgb565_t alpha_color;

	logic burst_empty;

	assign pix_ready_o = run_open & decay_in_ready;

	tmu_decay #(
		.fml_depth(fml_depth)
	) decay_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.brightness_i(brightness),
		.chroma_en_i(chroma_en),
		.chroma_key_i(chroma_key),
		.in_valid_i(pix_valid_i & run_open),
		.in_ready_o(decay_in_ready),
		.in_adr_i(pix_adr_i),
		.in_color_i(pix_color_i),
		.out_valid_o(decay_valid),
		.out_ready_i(decay_ready),
		.out_adr_o(decay_adr),
		.out_color_o(decay_color)
	);

	tmu_fdest #(
		.fml_depth(fml_depth)
	) fdest_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.alpha_i(alpha),
		.in_valid_i(decay_valid),
		.in_ready_o(decay_ready),
		.in_adr_i(decay_adr),
		.in_color_i(decay_color),
		.out_valid_o(fdest_valid),
		.out_ready_i(fdest_ready),
		.out_adr_o(fdest_adr),
		.out_color_o(fdest_color),
		.out_dcolor_o(fdest_dcolor),
		.dr_valid_o(dr_valid_o),
		.dr_ready_i(dr_ready_i),
		.dr_adr_o(dr_adr_o),
		.dr_rvalid_i(dr_rvalid_i),
		.dr_rdata_i(dr_rdata_i)
	);

	tmu_alpha #(
		.fml_depth(fml_depth)
	) alpha_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.alpha_i(alpha),
		.in_valid_i(fdest_valid),
		.in_ready_o(fdest_ready),
		.in_adr_i(fdest_adr),
		.in_color_i(fdest_color),
		.in_dcolor_i(fdest_dcolor),
		.out_valid_o(alpha_valid),
		.out_ready_i(alpha_ready),
		.out_adr_o(alpha_adr),
		.out_color_o(alpha_color)
	);

	tmu_burst #(
		.fml_depth(fml_depth)
	) burst_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush),
		.empty_o(burst_empty),
		.in_valid_i(alpha_valid),
		.in_ready_o(alpha_ready),
		.in_adr_i(alpha_adr),
		.in_color_i(alpha_color),
		.fw_valid_o(fw_valid_o),
		.fw_ready_i(fw_ready_i),
		.fw_adr_o(fw_adr_o),
		.fw_sel_o(fw_sel_o),
		.fw_data_o(fw_data_o)
	);

	// ####################
	// Run control
	logic [1:0] state;
	logic [1:0] next_state;
	logic [15:0] accepted;
	logic pipe_busy;

	assign run_open = (state == PROCESS) & (accepted != count);

	// fdest holding a pixel without offering it means a read is in flight
	assign pipe_busy = decay_valid | fdest_valid | ~decay_ready | alpha_valid | fw_valid_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			accepted <= '0;
		end else begin
			state <= next_state;
			if (start)
				accepted <= '0;
			else if (pix_valid_i & pix_ready_o)
				accepted <= accepted + 16'd1;
		end
	end

	always_comb begin
		next_state = state;
		flush = 1'b0;
		done = 1'b0;
		case (state)
			IDLE: if (start & ~busy) next_state = PROCESS;
			PROCESS: if (~run_open & ~pipe_busy) next_state = FLUSH;
			FLUSH: begin
				flush = 1'b1;  // Closes the last partial word
				next_state = WAIT_FLUSH;
			end
			WAIT_FLUSH: begin
				if (burst_empty) begin
					done = 1'b1;
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

endmodule

// ==== hw/tmu_burst.sv ====
/*
 * Burst assembler and framebuffer write port.
 * Collects pixels of one 64-bit word, four lanes of 16 bits, and marks
 * each filled lane in the byte selects. The open word is sent when a
 * pixel for another word arrives or when flush is pulsed. The write
 * register holds the word until the framebuffer accepts it.
 */
module tmu_burst #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic flush_i,
	output logic empty_o,

	input logic in_valid_i,
	output logic in_ready_o,
	input logic [fml_depth-2:0] in_adr_i,
	input tmu_pkg::rgb565_t in_color_i,

	output logic fw_valid_o,
	input logic fw_ready_i,
	output logic [fml_depth-4:0] fw_adr_o,
	output logic [7:0] fw_sel_o,
	output logic [63:0] fw_data_o
);
	import tmu_pkg::*;

	localparam int LANE_W = $clog2(PIX_PER_WORD);

	// ####################
	// Word being assembled
	logic [fml_depth-4:0] cur_adr;
	logic [2*PIX_PER_WORD-1:0] cur_sel;
	logic [16*PIX_PER_WORD-1:0] cur_data;

	logic [fml_depth-4:0] word_adr;
	logic [LANE_W-1:0] lane;
	logic [2*PIX_PER_WORD-1:0] lane_sel;
	logic open;
	logic other_word;
	logic out_free;
	logic accept;
	logic close;

	assign word_adr = in_adr_i[fml_depth-2:LANE_W];
	assign lane = in_adr_i[LANE_W-1:0];
	assign lane_sel = 2'b11 << (2 * lane);

	assign open = |cur_sel;  // Any lane filled means a word is open
	assign other_word = open & (word_adr != cur_adr);
	assign out_free = ~fw_valid_o | fw_ready_i;

	assign in_ready_o = ~other_word | out_free;  // Stall only if we cannot close
	assign accept = in_valid_i & in_ready_o;
	assign close = open & out_free & (flush_i | (in_valid_i & other_word));
	assign empty_o = ~open & ~fw_valid_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cur_sel <= '0;
			fw_valid_o <= 1'b0;
		end else begin
			if (fw_valid_o & fw_ready_i)
				fw_valid_o <= 1'b0;
			if (close)
				fw_valid_o <= 1'b1;
			// A closing word restarts the selects before the new lane goes in
			if (accept)
				cur_sel <= (close ? '0 : cur_sel) | lane_sel;
			else if (close)
				cur_sel <= '0;
		end
	end

	// ####################
	// Payload, lanes without a select bit keep stale data
	always_ff @(posedge sys_clk) begin
		if (close) begin
			fw_adr_o <= cur_adr;
			fw_sel_o <= cur_sel;
			fw_data_o <= cur_data;
		end
		if (accept) begin
			cur_adr <= word_adr;
			cur_data[16*lane +: 16] <= in_color_i.raw;
		end
	end

	a_fw_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fw_valid_o && !fw_ready_i |=> fw_valid_o && $stable(fw_adr_o)
			&& $stable(fw_sel_o) && $stable(fw_data_o));

endmodule

// ==== hw/tmu_alpha.sv ====
/*
 * Alpha blending stage.
 * Mixes the source color with the destination color fetched before it,
 * weighted by (alpha+1) and (63-alpha) over 64. At full opacity the
 * source passes unchanged. One cycle of latency.
 */
module tmu_alpha #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	input tmu_pkg::level_t alpha_i,

	input logic in_valid_i,
	output logic in_ready_o,
	input logic [fml_depth-2:0] in_adr_i,
	input tmu_pkg::rgb565_t in_color_i,
	input tmu_pkg::rgb565_t in_dcolor_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output logic [fml_depth-2:0] out_adr_o,
	output tmu_pkg::rgb565_t out_color_o
);
	import tmu_pkg::*;

	// The two weights always add up to 64
	function automatic logic [5:0] mix(input logic [5:0] s, input logic [5:0] d,
		input level_t a);
		logic [12:0] sum;
		sum = {7'd0, s} * ({7'd0, a} + 13'd1)
			+ {7'd0, d} * ({7'd0, LEVEL_MAX} - {7'd0, a});
		return sum[11:6];
	endfunction

	logic [5:0] mix_r;
	logic [5:0] mix_g;
	logic [5:0] mix_b;
	rgb565_t blended;

	assign mix_r = mix({1'b0, in_color_i.ch.r}, {1'b0, in_dcolor_i.ch.r}, alpha_i);
	assign mix_g = mix(in_color_i.ch.g, in_dcolor_i.ch.g, alpha_i);
	assign mix_b = mix({1'b0, in_color_i.ch.b}, {1'b0, in_dcolor_i.ch.b}, alpha_i);
	assign blended = {mix_r[4:0], mix_g, mix_b[4:0]};

	assign in_ready_o = ~out_valid_o | out_ready_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			out_valid_o <= 1'b0;
		else if (in_ready_o)
			out_valid_o <= in_valid_i;
	end

	// No destination was fetched at full opacity, so it must not be used
	always_ff @(posedge sys_clk) begin
		if (in_valid_i & in_ready_o) begin
			out_adr_o <= in_adr_i;
			out_color_o <= (alpha_i == LEVEL_MAX) ? in_color_i : blended;
		end
	end

endmodule

// ==== hw/tmu_fdest.sv ====
/*
 * Destination fetch stage for alpha blending.
 * Holds one pixel. While opacity is below full it reads the pixel at the
 * same framebuffer address and releases both colors once the response
 * is in. At full opacity no read is made and the pixel passes in a cycle.
 */
module tmu_fdest #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	input tmu_pkg::level_t alpha_i,

	input logic in_valid_i,
	output logic in_ready_o,
	input logic [fml_depth-2:0] in_adr_i,
	input tmu_pkg::rgb565_t in_color_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output logic [fml_depth-2:0] out_adr_o,
	output tmu_pkg::rgb565_t out_color_o,
	output tmu_pkg::rgb565_t out_dcolor_o,

	output logic dr_valid_o,
	input logic dr_ready_i,
	output logic [fml_depth-2:0] dr_adr_o,
	input logic dr_rvalid_i,
	input tmu_pkg::rgb565_t dr_rdata_i
);
	import tmu_pkg::*;

	logic full;  // A pixel sits in the stage
	logic pending;  // Read accepted, response not yet back
	logic blend;

	assign blend = (alpha_i < LEVEL_MAX);
	assign in_ready_o = ~full | (out_valid_o & out_ready_i);
	assign dr_adr_o = out_adr_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			full <= 1'b0;
			pending <= 1'b0;
			out_valid_o <= 1'b0;
			dr_valid_o <= 1'b0;
		end else begin
			if (out_valid_o & out_ready_i) begin
				out_valid_o <= 1'b0;
				full <= 1'b0;
			end
			if (dr_valid_o & dr_ready_i) begin
				dr_valid_o <= 1'b0;
				pending <= 1'b1;
			end
			if (dr_rvalid_i) begin
				pending <= 1'b0;
				out_valid_o <= 1'b1;
			end
			// A new pixel can enter in the cycle the old one leaves
			if (in_valid_i & in_ready_o) begin
				full <= 1'b1;
				if (blend)
					dr_valid_o <= 1'b1;
				else
					out_valid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (in_valid_i & in_ready_o) begin
			out_adr_o <= in_adr_i;
			out_color_o <= in_color_i;
		end
		if (dr_rvalid_i)
			out_dcolor_o <= dr_rdata_i;
	end

	// The memory side must never answer a read we did not make
	a_rvalid_pending: assert property (@(posedge sys_clk) disable iff (sys_rst)
		dr_rvalid_i |-> pending);

endmodule

// ==== hw/tmu_decay.sv ====
/*
 * Brightness decay and chroma key stage.
 * Scales each channel by (brightness+1)/64 and holds the result for one
 * cycle. Pixels that match the enabled key are taken and dropped.
 */
module tmu_decay #(
	parameter int fml_depth = 26
) (
	input logic sys_clk,
	input logic sys_rst,

	input tmu_pkg::level_t brightness_i,
	input logic chroma_en_i,
	input tmu_pkg::rgb565_t chroma_key_i,

	input logic in_valid_i,
	output logic in_ready_o,
	input logic [fml_depth-2:0] in_adr_i,
	input tmu_pkg::rgb565_t in_color_i,

	output logic out_valid_o,
	input logic out_ready_i,
	output logic [fml_depth-2:0] out_adr_o,
	output tmu_pkg::rgb565_t out_color_o
);
	import tmu_pkg::*;

	// Floor of channel times (level+1) over 64
	function automatic logic [5:0] scale(input logic [5:0] c, input level_t lvl);
		logic [12:0] prod;
		prod = {7'd0, c} * ({7'd0, lvl} + 13'd1);
		return prod[11:6];
	endfunction

	logic [5:0] dec_r;
	logic [5:0] dec_g;
	logic [5:0] dec_b;
	rgb565_t decayed;
	logic keyed;

	assign dec_r = scale({1'b0, in_color_i.ch.r}, brightness_i);
	assign dec_g = scale(in_color_i.ch.g, brightness_i);
	assign dec_b = scale({1'b0, in_color_i.ch.b}, brightness_i);
	assign decayed = {dec_r[4:0], dec_g, dec_b[4:0]};

	assign keyed = chroma_en_i & (in_color_i.raw == chroma_key_i.raw);  // Raw compare
	assign in_ready_o = ~out_valid_o | out_ready_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			out_valid_o <= 1'b0;
		else if (in_ready_o)
			out_valid_o <= in_valid_i & ~keyed;  // Keyed pixels vanish here
	end

	always_ff @(posedge sys_clk) begin
		if (in_valid_i & in_ready_o) begin
			out_adr_o <= in_adr_i;
			out_color_o <= decayed;
		end
	end

endmodule

// ==== hw/tmu_ctlif.sv ====
/*
 * Control register file of the pixel back end.
 * Answers CSR accesses on its own page, holds the run settings and turns
 * a write of bit 0 to the control register into a start pulse. Busy is
 * held from start until the top level reports done, and the interrupt
 * pulses for one cycle at that point.
 */
module tmu_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic [13:0] csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	input logic done_i,
	output logic irq_o,
	output logic start_o,
	output logic busy_o,

	output tmu_pkg::level_t brightness_o,
	output logic chroma_en_o,
	output tmu_pkg::rgb565_t chroma_key_o,
	output tmu_pkg::level_t alpha_o,
	output logic [15:0] count_o
);
	import tmu_pkg::*;

	logic csr_sel;
	logic [9:0] reg_idx;
	logic ctrl_wr;

	assign csr_sel = (csr_a_i[13:10] == csr_addr);  // Top bits select the page
	assign reg_idx = csr_a_i[9:0];
	assign ctrl_wr = csr_sel & csr_we_i & (reg_idx == REG_CTRL);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brightness_o <= LEVEL_MAX;
			chroma_en_o <= 1'b0;
			chroma_key_o <= '0;
			alpha_o <= LEVEL_MAX;
			count_o <= '0;
		end else if (csr_sel & csr_we_i) begin
			case (reg_idx)
				REG_BRIGHTNESS: brightness_o <= csr_di_i[5:0];
				REG_CHROMA: begin
					chroma_en_o <= csr_di_i[CHROMA_EN_BIT];
					chroma_key_o.raw <= csr_di_i[15:0];
				end
				REG_ALPHA: alpha_o <= csr_di_i[5:0];
				REG_COUNT: count_o <= csr_di_i[15:0];
				default: ;
			endcase
		end
	end

	// A start request during a run is ignored
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			start_o <= 1'b0;
			busy_o <= 1'b0;
			irq_o <= 1'b0;
		end else begin
			start_o <= ctrl_wr & csr_di_i[0] & ~busy_o & ~start_o;
			irq_o <= done_i;
			if (start_o)
				busy_o <= 1'b1;
			else if (done_i)
				busy_o <= 1'b0;
		end
	end

	// Reads return one cycle later and give zero outside our page
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_sel) begin
				case (reg_idx)
					REG_CTRL: csr_do_o <= {31'd0, busy_o};
					REG_BRIGHTNESS: csr_do_o <= {26'd0, brightness_o};
					REG_CHROMA: csr_do_o <= {15'd0, chroma_en_o, chroma_key_o.raw};
					REG_ALPHA: csr_do_o <= {26'd0, alpha_o};
					REG_COUNT: csr_do_o <= {16'd0, count_o};
					default: csr_do_o <= '0;
				endcase
			end
		end
	end

	// A start pulse never falls inside a run
	a_start_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		start_o |-> !busy_o);

endmodule

// ==== hw/tmu_pkg.sv ====
/*
 * Shared definitions for the TMU pixel back end.
 * Holds the RGB565 color word, the 6-bit level used for brightness and
 * opacity, the control register map and the framebuffer word layout.
 * Modules import it inside their bodies and use scoped names in ports.
 */
package tmu_pkg;

	// One pixel. The chroma key compares the raw word, while decay
	// and blending work on the separate channels
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} ch;
	} rgb565_t;

	typedef logic [5:0] level_t;  // 0 is darkest or fully transparent

	localparam level_t LEVEL_MAX = 6'd63;  // Full brightness, full opacity

	// ####################
	// Register indices within the control page
	localparam int REG_CTRL = 0;  // Write bit 0 to start, read bit 0 for busy
	localparam int REG_BRIGHTNESS = 1;
	localparam int REG_CHROMA = 2;  // Key color in 15:0, enable above it
	localparam int REG_ALPHA = 3;
	localparam int REG_COUNT = 4;  // Pixels in the next run

	localparam int CHROMA_EN_BIT = 16;

	// Four 16-bit pixels fill one 64-bit framebuffer write
	localparam int PIX_PER_WORD = 4;

endpackage
